// File: hdl/imul_pkg.sv
// ----------------------------
// shared types for the signed 32x32 iterative multiply unit
// operands are two's complement and products are full 64-bit width
// ----------------------------
`default_nettype none

package imul_pkg;

  // ----------------------------
  // widths and iteration count
  // ----------------------------

  // operand width in bits
  localparam int OPERAND_W = 32;

  // one shift-and-add step per multiplier bit
  localparam int ITER_COUNT = OPERAND_W;

  // ----------------------------
  // payload types
  // ----------------------------

  // single signed operand
  typedef logic signed [OPERAND_W-1:0] operand_t;

  // full signed product, twice the operand width
  typedef logic signed [2*OPERAND_W-1:0] product_t;

  // request pair as carried by the request queue
  // a sits in the upper half, b in the lower half
  typedef struct packed {
    operand_t a;
    operand_t b;
  } mul_req_t;

endpackage

`default_nettype wire

// File: hdl/msg_fifo.sv
// ----------------------------
// valid/ready FIFO for any packed payload type
// depth must be a power of two and at least 2
// ----------------------------
`default_nettype none

module msg_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 2
) (
  input  wire logic     clk,
  input  wire logic     reset,

  // write side
  input  wire payload_t in_data,
  input  wire logic     in_val,
  output logic          in_rdy,

  // read side
  output payload_t      out_data,
  output logic          out_val,
  input  wire logic     out_rdy
);

  // pointer wraps on its own since depth is a power of two
  localparam int ptr_w = $clog2(depth);
  // count needs one extra state for full
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [cnt_w-1:0] full_count = cnt_w'(depth);

  // storage
  payload_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  logic wr_fire;
  logic rd_fire;

  // ----------------------------
  // handshake levels
  // ----------------------------

  assign in_rdy   = (count != full_count);
  assign out_val  = (count != '0);
  // head entry is read straight from storage
  assign out_data = mem[rd_ptr];

  assign wr_fire = in_val && in_rdy;
  assign rd_fire = out_val && out_rdy;

  // ----------------------------
  // storage write
  // ----------------------------

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ----------------------------
  // pointers and occupancy
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous read and write leaves the count alone
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------
  // checks
  // ----------------------------

  // occupancy bounded by the buffer size
  count_in_range_a: assert property (
    @(posedge clk) disable iff (reset) count <= full_count
  );

  // stalled head entry must hold still for the downstream consumer
  out_data_stable_a: assert property (
    @(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> $stable(out_data)
  );

endmodule

`default_nettype wire

// File: hdl/imul_iter_ctrl.sv
// ----------------------------
// FSM for the iterative multiplier, one request in flight at a time
// result is offered until the response side takes it
// ----------------------------
`default_nettype none

module imul_iter_ctrl (
  input  wire logic clk,
  input  wire logic reset,

  // request handshake from the request queue
  input  wire logic mul_req_val,
  output logic      mul_req_rdy,

  // response handshake toward the response queue
  output logic      mul_resp_val,
  input  wire logic mul_resp_rdy,

  // datapath strobes
  output logic      load,
  output logic      step
);

  import imul_pkg::*;

  // step counter covers 0 .. ITER_COUNT-1
  localparam int cnt_w = $clog2(ITER_COUNT);
  localparam logic [cnt_w-1:0] last_step = cnt_w'(ITER_COUNT - 1);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_t;

  state_t           state;
  logic [cnt_w-1:0] step_cnt;

  // ----------------------------
  // outputs from state only
  // ----------------------------

  assign mul_req_rdy  = (state == st_idle);
  assign mul_resp_val = (state == st_done);
  // accept cycle doubles as the operand load
  assign load         = mul_req_val && mul_req_rdy;
  assign step         = (state == st_calc);

  // ----------------------------
  // state and step counter
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (load) begin
            state    <= st_calc;
            step_cnt <= '0;
          end
        end
        st_calc: begin
          // last shift-and-add goes out on this edge
          if (step_cnt == last_step) begin
            state <= st_done;
          end
          step_cnt <= step_cnt + 1'b1;
        end
        st_done: begin
          // hold the result until the response queue has room
          if (mul_resp_val && mul_resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------
  // checks
  // ----------------------------

  state_legal_a: assert property (
    @(posedge clk) disable iff (reset) state inside {st_idle, st_calc, st_done}
  );

  load_step_excl_a: assert property (
    @(posedge clk) disable iff (reset) !(load && step)
  );

  // one load cycle plus ITER_COUNT steps before the result is offered
  resp_latency_a: assert property (
    @(posedge clk) disable iff (reset) load |-> ##(ITER_COUNT + 1) mul_resp_val
  );

endmodule

`default_nettype wire

// File: hdl/imul_iter_dpath.sv
// ----------------------------
// shift-and-add datapath on operand magnitudes, sign fixed at the output
// operands are sampled only on load
// ----------------------------
`default_nettype none

module imul_iter_dpath (
  input  wire logic                clk,
  input  wire logic                reset,

  // request operands straight from the request queue head
  input  wire imul_pkg::operand_t  req_a,
  input  wire imul_pkg::operand_t  req_b,

  // strobes from the control FSM
  input  wire logic                load,
  input  wire logic                step,

  // signed product, valid once the FSM reaches done
  output imul_pkg::product_t       result
);

  import imul_pkg::*;

  localparam int prod_w = 2 * OPERAND_W;

  // magnitudes of the incoming operands
  logic [OPERAND_W-1:0] mag_a;
  logic [OPERAND_W-1:0] mag_b;

  // stored signs
  logic sign_a_q;
  logic sign_b_q;

  // multiplicand shifts left, multiplier shifts right
  logic [prod_w-1:0]    mcand_q;
  logic [OPERAND_W-1:0] mplier_q;

  // running unsigned product
  logic [prod_w-1:0] acc_q;
  logic [prod_w-1:0] acc_sum;

  logic neg_result;

  // ----------------------------
  // magnitude conversion
  // ----------------------------

  // most negative input maps to 2**31, still exact in 32 unsigned bits
  assign mag_a = req_a[OPERAND_W-1] ? (~req_a + 1'b1) : req_a;
  assign mag_b = req_b[OPERAND_W-1] ? (~req_b + 1'b1) : req_b;

  // ----------------------------
  // shift-and-add step
  // ----------------------------

  // add only when the current multiplier bit is set
  assign acc_sum = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  // operand shift registers
  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {{OPERAND_W{1'b0}}, mag_a};
      mplier_q <= mag_b;
    end else if (step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // accumulator and signs
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q    <= '0;
      sign_a_q <= 1'b0;
      sign_b_q <= 1'b0;
    end else if (load) begin
      acc_q    <= '0;
      sign_a_q <= req_a[OPERAND_W-1];
      sign_b_q <= req_b[OPERAND_W-1];
    end else if (step) begin
      acc_q <= acc_sum;
    end
  end

  // ----------------------------
  // sign correction
  // ----------------------------

  // negative exactly when the operand signs differ
  assign neg_result = sign_a_q ^ sign_b_q;

  // acc never exceeds 2**62 so the negation cannot overflow
  assign result = neg_result ? product_t'(~acc_q + 1'b1) : product_t'(acc_q);

endmodule

`default_nettype wire

// File: hdl/imul_unit.sv
// ----------------------------
// queued signed 32x32 multiply, request queue, iterative core, response queue
// queue depths must be powers of two, at least 2
// ----------------------------
`default_nettype none

module imul_unit #(
  parameter int req_depth  = 4,
  parameter int resp_depth = 4
) (
  input  wire logic               clk,
  input  wire logic               reset,

  // request side
  input  wire imul_pkg::operand_t req_a,
  input  wire imul_pkg::operand_t req_b,
  input  wire logic               req_val,
  output logic                    req_rdy,

  // response side
  output imul_pkg::product_t      resp_result,
  output logic                    resp_val,
  input  wire logic               resp_rdy
);

  import imul_pkg::*;

  // packed pair into and out of the request queue
  mul_req_t req_pair;
  mul_req_t mul_req;

  // core handshakes
  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;

  // control to datapath strobes
  logic load;
  logic step;

  product_t mul_result;

  assign req_pair = '{a: req_a, b: req_b};

  // ----------------------------
  // request queue
  // ----------------------------

  msg_fifo #(
    .payload_t (mul_req_t),
    .depth     (req_depth)
  ) req_queue_i (
    .clk      (clk),
    .reset    (reset),
    .in_data  (req_pair),
    .in_val   (req_val),
    .in_rdy   (req_rdy),
    .out_data (mul_req),
    .out_val  (mul_req_val),
    .out_rdy  (mul_req_rdy)
  );

  // ----------------------------
  // multiply core
  // ----------------------------

  imul_iter_ctrl ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .load         (load),
    .step         (step)
  );

  // operands taken from the queue head, captured on load
  imul_iter_dpath dpath_i (
    .clk    (clk),
    .reset  (reset),
    .req_a  (mul_req.a),
    .req_b  (mul_req.b),
    .load   (load),
    .step   (step),
    .result (mul_result)
  );

  // ----------------------------
  // response queue
  // ----------------------------

  msg_fifo #(
    .payload_t (product_t),
    .depth     (resp_depth)
  ) resp_queue_i (
    .clk      (clk),
    .reset    (reset),
    .in_data  (mul_result),
    .in_val   (mul_resp_val),
    .in_rdy   (mul_resp_rdy),
    .out_data (resp_result),
    .out_val  (resp_val),
    .out_rdy  (resp_rdy)
  );

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
// ----------------------------
// testbench clock and synchronous reset source
// reset is released with a non-blocking update on a rising edge
// ----------------------------
`default_nettype none

module clk_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic reset
);

  // free running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held high for the first reset_cycles rising edges
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/imul_unit_tb.sv
// ----------------------------
// random and corner stimulus for imul_unit, checked against a signed 64-bit model
// stops at the first mismatch, a watchdog bounds the run
// ----------------------------
`default_nettype none

module imul_unit_tb;

  import imul_pkg::*;

  // ----------------------------
  // run length
  // ----------------------------

  localparam int n_random    = 40;
  localparam int n_corner    = 25;
  localparam int n_latency   = 3;
  localparam int n_bursts    = 6;
  localparam int burst_max   = 12;
  localparam int total_reqs  = n_random + n_corner + n_latency + n_bursts * burst_max;
  // 40 cycles per request, period 4, back-pressure factor 4
  localparam int watchdog_t  = total_reqs * 40 * 4 * 4;
  // request queue 1, core load plus ITER_COUNT steps, response queue 1
  localparam int exp_latency = 1 + (ITER_COUNT + 1) + 1;

  logic     clk;
  logic     reset;
  operand_t req_a;
  operand_t req_b;
  logic     req_val;
  logic     req_rdy;
  product_t resp_result;
  logic     resp_val;
  logic     resp_rdy;

  // random back-pressure enable, updated on clock edges only
  logic     bp_on;

  // model products in request order
  product_t expected_q[$];
  int       sent_count;
  int       recv_count;

  operand_t corners [5] = '{32'sd0, 32'sd1, -32'sd1, 32'sh7fffffff, 32'sh80000000};

  clk_gen #(.period(4), .reset_cycles(4)) clk_gen_i (.clk(clk), .reset(reset));

  imul_unit #(.req_depth(4), .resp_depth(4)) dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------
  // model and check
  // ----------------------------

  // full-width signed multiply after sign extension
  function automatic product_t model_product(input operand_t a, input operand_t b);
    product_t wide_a;
    product_t wide_b;
    wide_a = a;
    wide_b = b;
    return wide_a * wide_b;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // ----------------------------
  // scoreboard
  // ----------------------------

  // values read at the edge are the ones set by the previous edge
  always @(posedge clk) begin
    if (!reset) begin
      // a full request queue implies requests in flight
      if (!req_rdy) begin
        check_value(expected_q.size() > 0, 1'b1, "req_rdy low with nothing outstanding");
      end
      if (resp_val && resp_rdy) begin
        check_value(expected_q.size() > 0, 1'b1, "response with no request outstanding");
        check_value(resp_result, expected_q.pop_front(), "product");
        recv_count++;
      end
    end
  end

  // ----------------------------
  // stimulus tasks, all entered on a rising edge
  // ----------------------------

  // offer one request and hold it until the transfer edge
  task send_req(input operand_t a, input operand_t b);
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    expected_q.push_back(model_product(a, b));
    sent_count++;
  endtask

  task stop_req();
    req_val <= 1'b0;
  endtask

  // returns once every sent request has come back
  task wait_drain();
    while (expected_q.size() != 0) @(posedge clk);
    @(posedge clk);
  endtask

  // entered on the transfer edge, counts edges until resp_val is seen
  task measure_latency();
    int lat;
    lat = 0;
    while (!resp_val) begin
      @(posedge clk);
      lat++;
    end
    check_value(lat, exp_latency, "request to response latency");
  endtask

  // resp_rdy held high, or random levels with random hold lengths
  task drive_ready();
    int unsigned hold;
    hold = 0;
    forever begin
      @(posedge clk);
      if (!bp_on) begin
        resp_rdy <= 1'b1;
      end else if (hold == 0) begin
        resp_rdy <= ($urandom_range(1, 0) == 1);
        hold = $urandom_range(60, 1);
      end else begin
        hold--;
      end
    end
  endtask

  // ----------------------------
  // main sequence
  // ----------------------------

  initial begin
    int len;
    req_a       = '0;
    req_b       = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    bp_on       = 1'b0;
    sent_count  = 0;
    recv_count  = 0;
    void'($urandom(6649));
    // child process seeded from this one
    fork
      drive_ready();
    join_none

    @(posedge clk);
    while (reset) @(posedge clk);
    check_value(resp_val, 1'b0, "resp_val after reset");
    check_value(req_rdy, 1'b1, "req_rdy after reset");

    // random pairs, back to back
    for (int i = 0; i < n_random; i++) begin
      send_req(operand_t'($urandom()), operand_t'($urandom()));
    end
    stop_req();
    wait_drain();

    // every sign combination of the corner values
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_req(corners[i], corners[j]);
      end
    end
    stop_req();
    wait_drain();

    // single requests into empty queues
    for (int k = 0; k < n_latency; k++) begin
      send_req(operand_t'($urandom()), operand_t'($urandom()));
      stop_req();
      measure_latency();
      wait_drain();
    end

    // bursts under random back-pressure
    bp_on <= 1'b1;
    for (int b = 0; b < n_bursts; b++) begin
      len = $urandom_range(burst_max, 1);
      for (int i = 0; i < len; i++) begin
        send_req(operand_t'($urandom()), operand_t'($urandom()));
      end
      stop_req();
      repeat ($urandom_range(20, 0)) @(posedge clk);
    end
    bp_on <= 1'b0;
    wait_drain();

    // late extra responses would show up here
    repeat (10) @(posedge clk);
    check_value(recv_count, sent_count, "response count");

    $display("all tests passed");
    $finish;
  end

  // ----------------------------
  // watchdog
  // ----------------------------

  initial begin
    #(watchdog_t);
    $display("timeout: run did not finish within %0d time units", watchdog_t);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/imul_pkg.sv
hdl/msg_fifo.sv
hdl/imul_iter_ctrl.sv
hdl/imul_iter_dpath.sv
hdl/imul_unit.sv
dv/clk_gen.sv
dv/imul_unit_tb.sv
